// File: vlog.f
+incdir+source
source/zxuno_pkg.sv
source/zxuno_port_decode.sv
source/zxuno_config_reg.sv
source/zxuno_register_bank.sv
source/cpu_din_mux.sv
source/zxuno_regbus.sv
dv/regbus_checker.sv
dv/tb_zxuno_regbus.sv

// File: dv/tb_zxuno_regbus.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module tb_zxuno_regbus;

  localparam int CLK_PERIOD = 10;
  // Sum of the bus operations over the five tests
  localparam int TOTAL_OPS  = 7 + 8 + 9 + 10 + 5;
  localparam int TIMEOUT_NS = 2 * TOTAL_OPS * 4 * CLK_PERIOD;
  localparam logic WR = 1'b1;
  localparam logic RD = 1'b0;
  localparam zxuno_pkg::cpu_bus_t IDLE_BUS = '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1,
                                               rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};

  logic sysclk = 1'b0;
  logic reset;
  zxuno_pkg::cpu_bus_t bus;
  logic [7:0] ula_dout;
  logic [7:0] cpudin;
  zxuno_pkg::dev_options_t dev_options;
  zxuno_pkg::scndbl_ctrl_t scndbl_ctrl;

  // Expected values and checker control
  logic [7:0] exp_cpudin;
  zxuno_pkg::dev_options_t exp_dev;
  zxuno_pkg::scndbl_ctrl_t exp_scn;
  logic chk;
  logic test_end;
  logic all_done;
  int test_id;
  int errors;

  // Model of the address register and the three registers
  logic [7:0] m_addr = 8'h00;
  logic [7:0] m_dev = `DEVOPTIONS_RESET;
  logic [7:0] m_scn = `SCNDBLCTRL_RESET;
  logic [7:0] m_scr = `SCRATCH_RESET;
  logic [7:0] reg_nums [3] = '{`REG_DEVOPTIONS, `REG_SCNDBLCTRL, `REG_SCRATCH};
  logic [31:0] rng_state = 32'h3c01;
  logic [7:0] val;
  logic [15:0] other_port;

  always #(CLK_PERIOD / 2) sysclk = ~sysclk;

  zxuno_regbus UUT (.sysclk(sysclk), .reset(reset), .bus(bus), .ula_dout(ula_dout),
                    .cpudin(cpudin), .dev_options(dev_options), .scndbl_ctrl(scndbl_ctrl));

  regbus_checker result_check (.sysclk(sysclk), .chk(chk), .test_end(test_end),
                               .all_done(all_done), .test_id(test_id),
                               .exp_cpudin(exp_cpudin), .exp_dev(exp_dev),
                               .exp_scn(exp_scn), .cpudin(cpudin),
                               .dev_options(dev_options), .scndbl_ctrl(scndbl_ctrl),
                               .total_errors(errors));

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  // Intack first, then address port, selected register and ULA
  function automatic logic [7:0] ref_cpudin(input zxuno_pkg::cpu_bus_t b, input logic [7:0] ula);
    logic io_read;
    io_read = !b.iorq_n && !b.rd_n;
    if (!b.iorq_n && !b.m1_n) return `INTACK_DATA;
    if (io_read && b.addr == `ZXUNO_ADDR_PORT) return m_addr;
    if (io_read && b.addr == `ZXUNO_DATA_PORT) begin
      case (m_addr)
        `REG_DEVOPTIONS: return m_dev;
        `REG_SCNDBLCTRL: return m_scn;
        `REG_SCRATCH:    return m_scr;
        default:         return ula;
      endcase
    end
    return ula;
  endfunction

  // Field layouts from bit 0 up
  function automatic zxuno_pkg::dev_options_t to_dev_options(input logic [7:0] v);
    zxuno_pkg::dev_options_t r;
    r.disable_ay       = v[0];
    r.disable_turboay  = v[1];
    r.disable_7ffd     = v[2];
    r.disable_1ffd     = v[3];
    r.disable_romsel7f = v[4];
    r.disable_romsel1f = v[5];
    r.enable_timexmmu  = v[6];
    r.disable_spisd    = v[7];
    return r;
  endfunction

  function automatic zxuno_pkg::scndbl_ctrl_t to_scndbl(input logic [7:0] v);
    zxuno_pkg::scndbl_ctrl_t r;
    r.vga_enable       = v[0];
    r.scanlines_enable = v[1];
    r.freq_option      = v[4:2];
    r.csync_option     = v[5];
    r.cpu_speed        = v[7:6];
    return r;
  endfunction

  task automatic update_model(input zxuno_pkg::cpu_bus_t b);
    if (b.addr == `ZXUNO_ADDR_PORT) begin
      m_addr = b.dout;
    end else if (b.addr == `ZXUNO_DATA_PORT) begin
      case (m_addr)
        `REG_DEVOPTIONS: m_dev = b.dout;
        `REG_SCNDBLCTRL: m_scn = b.dout;
        `REG_SCRATCH:    m_scr = b.dout;
        default: ;
      endcase
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  // Bus held three cycles and checked in the last one
  task automatic bus_op(input logic [15:0] addr, input logic [7:0] data, input logic is_wr,
                        input logic is_intack);
    zxuno_pkg::cpu_bus_t b;
    logic [7:0] ula;
    b = '{addr: addr, dout: data, iorq_n: 1'b0, rd_n: is_wr, wr_n: !is_wr, m1_n: !is_intack};
    rng_state = xorshift32(rng_state);
    ula = rng_state[7:0];
    @(posedge sysclk);
    bus <= b;
    ula_dout <= ula;
    exp_cpudin <= ref_cpudin(b, ula);
    if (is_wr) update_model(b);
    exp_dev <= to_dev_options(m_dev);
    exp_scn <= to_scndbl(m_scn);
    repeat (2) @(posedge sysclk);
    chk <= 1'b1;
    @(posedge sysclk);
    chk <= 1'b0;
    bus <= IDLE_BUS;
  endtask

  task automatic finish_test;
    @(posedge sysclk);
    test_end <= 1'b1;
    @(posedge sysclk);
    test_end <= 1'b0;
    test_id <= test_id + 1;
  endtask

  initial begin
    bus = IDLE_BUS;
    ula_dout = 8'h00;
    reset = 1'b1;
    chk = 1'b0;
    test_end = 1'b0;
    all_done = 1'b0;
    test_id = 1;
    repeat (3) @(posedge sysclk);
    reset <= 1'b0;
    // Reset values
    bus_op(`ZXUNO_ADDR_PORT, 8'h00, RD, 1'b0);
    for (int i = 0; i < 3; i++) begin
      bus_op(`ZXUNO_ADDR_PORT, reg_nums[i], WR, 1'b0);
      bus_op(`ZXUNO_DATA_PORT, 8'h00, RD, 1'b0);
    end
    finish_test();
    // Register number round trip
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      bus_op(`ZXUNO_ADDR_PORT, rng_state[15:8], WR, 1'b0);
      bus_op(`ZXUNO_ADDR_PORT, 8'h00, RD, 1'b0);
    end
    finish_test();
    // Write and read back each register
    for (int i = 0; i < 3; i++) begin
      rng_state = xorshift32(rng_state);
      bus_op(`ZXUNO_ADDR_PORT, reg_nums[i], WR, 1'b0);
      bus_op(`ZXUNO_DATA_PORT, rng_state[23:16], WR, 1'b0);
      bus_op(`ZXUNO_DATA_PORT, 8'h00, RD, 1'b0);
    end
    finish_test();
    // Back to back writes to two registers
    rng_state = xorshift32(rng_state);
    val = rng_state[7:0];
    bus_op(`ZXUNO_ADDR_PORT, `REG_DEVOPTIONS, WR, 1'b0);
    bus_op(`ZXUNO_DATA_PORT, val, WR, 1'b0);
    bus_op(`ZXUNO_ADDR_PORT, `REG_SCNDBLCTRL, WR, 1'b0);
    bus_op(`ZXUNO_DATA_PORT, val ^ 8'h5A, WR, 1'b0);
    for (int i = 0; i < 3; i++) begin
      bus_op(`ZXUNO_ADDR_PORT, reg_nums[i], WR, 1'b0);
      bus_op(`ZXUNO_DATA_PORT, 8'h00, RD, 1'b0);
    end
    finish_test();
    // Unimplemented register, foreign port and interrupt acknowledge
    rng_state = xorshift32(rng_state);
    val = rng_state[7:0];
    if (val == `REG_DEVOPTIONS || val == `REG_SCNDBLCTRL || val == `REG_SCRATCH) val ^= 8'h01;
    other_port = rng_state[31:16];
    if (other_port == `ZXUNO_ADDR_PORT || other_port == `ZXUNO_DATA_PORT) other_port ^= 16'h1;
    bus_op(`ZXUNO_ADDR_PORT, val, WR, 1'b0);
    bus_op(`ZXUNO_DATA_PORT, 8'h00, RD, 1'b0);
    bus_op(other_port, 8'h00, RD, 1'b0);
    bus_op(`ZXUNO_DATA_PORT, 8'h00, RD, 1'b1);
    bus_op(`ZXUNO_ADDR_PORT, 8'h00, RD, 1'b1);
    finish_test();
    @(posedge sysclk);
    all_done <= 1'b1;
    @(posedge sysclk);
    all_done <= 1'b0;
    @(posedge sysclk);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Run did not complete within %0d ns, stopped by watchdog", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: dv/regbus_checker.sv
`timescale 1ns/1ns

module regbus_checker (
  input  logic                    sysclk,
  input  logic                    chk,
  input  logic                    test_end,
  input  logic                    all_done,
  input  int                      test_id,
  input  logic [7:0]              exp_cpudin,
  input  zxuno_pkg::dev_options_t exp_dev,
  input  zxuno_pkg::scndbl_ctrl_t exp_scn,
  input  logic [7:0]              cpudin,
  input  zxuno_pkg::dev_options_t dev_options,
  input  zxuno_pkg::scndbl_ctrl_t scndbl_ctrl,
  output int                      total_errors
);

  // Running totals and per test counters
  int total_checks;
  int tests_done;
  int test_checks;
  int test_errors;

  initial begin
    total_errors = 0;
    total_checks = 0;
    tests_done   = 0;
    test_checks  = 0;
    test_errors  = 0;
  end

  // One byte compare, error line at once on mismatch
  task automatic compare8(input string name, input logic [7:0] exp, input logic [7:0] act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errors++;
      total_errors++;
      $display("ERROR test %0d: %s expected %h actual %h", test_id, name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Sampling on the falling edge, outputs settled
  // ----------------------------------------------------------

  always @(negedge sysclk) begin
    // Last cycle of a bus operation
    if (chk) begin
      compare8("cpudin", exp_cpudin, cpudin);
      compare8("dev_options", exp_dev, dev_options);
      compare8("scndbl_ctrl", exp_scn, scndbl_ctrl);
    end
    if (test_end) begin
      $display("Test %0d finished: %0d checks, %0d errors", test_id, test_checks,
               test_errors);
      tests_done++;
      test_checks = 0;
      test_errors = 0;
    end
    // Closing counts
    if (all_done) begin
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, total_checks,
               total_errors);
    end
  end

endmodule

// File: source/zxuno_regbus.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module zxuno_regbus (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::cpu_bus_t     bus,
  input  logic [7:0]              ula_dout,
  output logic [7:0]              cpudin,
  output zxuno_pkg::dev_options_t dev_options,
  output zxuno_pkg::scndbl_ctrl_t scndbl_ctrl
);

  // ----------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------

  // Decode to register bank
  zxuno_pkg::reg_access_t reg_access;

  // Read candidates into the data mux
  zxuno_pkg::read_item_t addr_item;
  zxuno_pkg::read_item_t reg_item;

  // Port decode and register number
  zxuno_port_decode port_decode (
    .sysclk     (sysclk),
    .reset      (reset),
    .bus        (bus),
    .reg_access (reg_access),
    .addr_item  (addr_item)
  );

  // Configuration registers
  zxuno_register_bank register_bank (
    .sysclk      (sysclk),
    .reset       (reset),
    .access      (reg_access),
    .dev_options (dev_options),
    .scndbl_ctrl (scndbl_ctrl),
    .reg_item    (reg_item)
  );

  // CPU data input select
  cpu_din_mux din_mux (
    .bus       (bus),
    .addr_item (addr_item),
    .reg_item  (reg_item),
    .ula_dout  (ula_dout),
    .cpudin    (cpudin)
  );

endmodule

// File: source/cpu_din_mux.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module cpu_din_mux (
  input  zxuno_pkg::cpu_bus_t   bus,
  input  zxuno_pkg::read_item_t addr_item,
  input  zxuno_pkg::read_item_t reg_item,
  input  logic [7:0]            ula_dout,
  output logic [7:0]            cpudin
);

  // ----------------------------------------------------------
  // Interrupt acknowledge
  // ----------------------------------------------------------

  // M1 together with IORQ needs no port decode
  logic oe_intack;

  assign oe_intack = !bus.iorq_n && !bus.m1_n;

  // ----------------------------------------------------------
  // Fixed priority select
  // ----------------------------------------------------------

  // Highest first, several sources may be active at once
  always_comb begin
    case (1'b1)
      // Vector byte for IM 2 and RST 38h in IM 1
      oe_intack: begin
        cpudin = `INTACK_DATA;
      end
      // Register number port
      addr_item.oe: begin
        cpudin = addr_item.data;
      end
      // Selected internal register
      reg_item.oe: begin
        cpudin = reg_item.data;
      end
      // Anything else belongs to the ULA
      default: begin
        cpudin = ula_dout;
      end
    endcase
  end

endmodule

// File: source/zxuno_register_bank.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module zxuno_register_bank (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::reg_access_t  access,
  output zxuno_pkg::dev_options_t dev_options,
  output zxuno_pkg::scndbl_ctrl_t scndbl_ctrl,
  output zxuno_pkg::read_item_t   reg_item
);

  localparam int NUM_REGS = 3;

  // Read candidates, one per register
  zxuno_pkg::read_item_t items [NUM_REGS];

  // ----------------------------------------------------------
  // Register instances
  // ----------------------------------------------------------

  // Device options
  zxuno_config_reg #(
    .payload_t (zxuno_pkg::dev_options_t),
    .REG_NUM   (`REG_DEVOPTIONS)
  ) devoptions_reg (
    .sysclk      (sysclk),
    .reset       (reset),
    .reset_value (zxuno_pkg::dev_options_t'(`DEVOPTIONS_RESET)),
    .access      (access),
    .value       (dev_options),
    .item        (items[0])
  );

  // Scandoubler control
  zxuno_config_reg #(
    .payload_t (zxuno_pkg::scndbl_ctrl_t),
    .REG_NUM   (`REG_SCNDBLCTRL)
  ) scndblctrl_reg (
    .sysclk      (sysclk),
    .reset       (reset),
    .reset_value (zxuno_pkg::scndbl_ctrl_t'(`SCNDBLCTRL_RESET)),
    .access      (access),
    .value       (scndbl_ctrl),
    .item        (items[1])
  );

  // Scratch byte, only reachable through the data port
  zxuno_config_reg #(
    .payload_t (logic [7:0]),
    .REG_NUM   (`REG_SCRATCH)
  ) scratch_reg (
    .sysclk      (sysclk),
    .reset       (reset),
    .reset_value (`SCRATCH_RESET),
    .access      (access),
    .value       (),
    .item        (items[2])
  );

  // ----------------------------------------------------------
  // Read back merge
  // ----------------------------------------------------------

  // Register numbers are distinct so an OR of gated data is enough
  // Unknown numbers leave oe low and the ULA wins downstream
  always_comb begin
    reg_item = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      reg_item.oe   = reg_item.oe | items[i].oe;
      reg_item.data = reg_item.data | (items[i].data & {8{items[i].oe}});
    end
  end

endmodule

// File: source/zxuno_config_reg.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module zxuno_config_reg #(
  parameter type        payload_t = logic [7:0],
  parameter logic [7:0] REG_NUM   = `REG_SCRATCH
) (
  input  logic                   sysclk,
  input  logic                   reset,
  input  payload_t               reset_value,
  input  zxuno_pkg::reg_access_t access,
  output payload_t               value,
  output zxuno_pkg::read_item_t  item
);

  // Selected by the current register number
  logic hit;

  assign hit = (access.addr == REG_NUM);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // One load per bus write, seen from the next clock on
  always_ff @(posedge sysclk) begin
    if (reset) begin
      value <= reset_value;
    end else if (access.wr && hit) begin
      value <= payload_t'(access.wdata);
    end
  end

  // ----------------------------------------------------------
  // Read back
  // ----------------------------------------------------------

  // Only flagged while the CPU reads this register
  assign item.oe = access.rd && hit;

  // Payload is always one byte wide
  assign item.data = value;

endmodule

// File: source/zxuno_port_decode.sv
`timescale 1ns/1ns
`include "zxuno_settings.svh"

module zxuno_port_decode (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxuno_pkg::cpu_bus_t    bus,
  output zxuno_pkg::reg_access_t reg_access,
  output zxuno_pkg::read_item_t  addr_item
);

  // ----------------------------------------------------------
  // Port match on the full 16 bit address
  // ----------------------------------------------------------

  logic addr_port_hit;
  logic data_port_hit;
  logic io_rd;
  logic io_wr;

  assign addr_port_hit = (bus.addr == `ZXUNO_ADDR_PORT);
  assign data_port_hit = (bus.addr == `ZXUNO_DATA_PORT);

  // I/O cycle qualifiers
  assign io_rd = !bus.iorq_n && !bus.rd_n;
  assign io_wr = !bus.iorq_n && !bus.wr_n;

  // ----------------------------------------------------------
  // Register number latch
  // ----------------------------------------------------------

  logic [7:0] reg_addr;
  logic       addr_wr;

  assign addr_wr = addr_port_hit && io_wr;

  // Reloads the same byte while the write is held, harmless
  always_ff @(posedge sysclk) begin
    if (reset) begin
      reg_addr <= 8'h00;
    end else if (addr_wr) begin
      reg_addr <= bus.dout;
    end
  end

  // Read back of the selected number
  assign addr_item.oe   = addr_port_hit && io_rd;
  assign addr_item.data = reg_addr;

  // ----------------------------------------------------------
  // Data port strobes
  // ----------------------------------------------------------

  logic data_wr_cond;
  logic data_wr_seen;

  assign data_wr_cond = data_port_hit && io_wr;

  // Remembers that this bus write already produced its pulse
  always_ff @(posedge sysclk) begin
    if (reset) begin
      data_wr_seen <= 1'b0;
    end else begin
      data_wr_seen <= data_wr_cond;
    end
  end

  // Rising edge of the write condition
  assign reg_access.wr = data_wr_cond && !data_wr_seen;

  // Read is a plain level
  assign reg_access.rd = data_port_hit && io_rd;

  assign reg_access.addr  = reg_addr;
  assign reg_access.wdata = bus.dout;

endmodule

// File: source/zxuno_pkg.sv
package zxuno_pkg;

  // ----------------------------------------------------------
  // CPU side of the bus
  // ----------------------------------------------------------

  // Z80 outputs as seen by the core, control lines active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } cpu_bus_t;

  // Decoded data port access towards the register bank
  // wr lasts one clock per bus write, rd follows the bus
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       rd;
    logic       wr;
  } reg_access_t;

  // One candidate for the CPU data input
  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } read_item_t;

  // ----------------------------------------------------------
  // Register layouts
  // ----------------------------------------------------------

  // Device options, first field is bit 7
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_options_t;

  // Scandoubler control
  // cpu_speed in bits 7:6, freq_option in bits 4:2
  typedef struct packed {
    logic [1:0] cpu_speed;
    logic       csync_option;
    logic [2:0] freq_option;
    logic       scanlines_enable;
    logic       vga_enable;
  } scndbl_ctrl_t;

endpackage

// File: source/zxuno_settings.svh
`ifndef ZXUNO_SETTINGS_SVH
`define ZXUNO_SETTINGS_SVH

// ----------------------------------------------------------
// I/O ports of the register bus
// ----------------------------------------------------------

// Address register, selects the internal register number
`define ZXUNO_ADDR_PORT 16'hFC3B

// Data port, reaches the register selected above
`define ZXUNO_DATA_PORT 16'hFD3B

// ----------------------------------------------------------
// Internal register numbers
// ----------------------------------------------------------

// Scandoubler and CPU speed control
`define REG_SCNDBLCTRL 8'h0B

// Peripheral enable and disable bits
`define REG_DEVOPTIONS 8'h0E

// Free scratch byte for software
`define REG_SCRATCH 8'hFE

// ----------------------------------------------------------
// Fixed bus values
// ----------------------------------------------------------

// Forced onto the data bus on interrupt acknowledge
`define INTACK_DATA 8'hFF

// Power up contents of each register
`define SCNDBLCTRL_RESET 8'h00
`define DEVOPTIONS_RESET 8'h00
`define SCRATCH_RESET 8'h00

`endif
